// File: build.f
hw/core_pkg.sv
hw/register_file.sv
hw/if_stage.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/controller.sv
hw/riscv_core.sv
tb/core_chk.sv
tb/core_tb.sv

// File: tb/core_testdata.hex
// Word 0 program length, word 1 store count, then one program word per line
// Last section holds expected stores, address then data per line
00000021
00000008
00001537 // lui  x10, 0x1
123450b7 // lui  x1, 0x12345
67808093 // addi x1, x1, 0x678
00152023 // sw   x1, 0(x10)
fff0c113 // xori x2, x1, -1
0f017193 // andi x3, x2, 0x0f0
5051e213 // ori  x4, x3, 0x505
402202b3 // sub  x5, x4, x2
00552223 // sw   x5, 4(x10)
00328333 // add  x6, x5, x3
006123b3 // slt  x7, x2, x6
00734433 // xor  x8, x6, x7
00852423 // sw   x8, 8(x10)
00508013 // addi x0, x1, 5
007004b3 // add  x9, x0, x7
00952623 // sw   x9, 12(x10)
00052823 // sw   x0, 16(x10)
00938463 // beq  x7, x9, +8 taken
00152a23 // sw   x1, 20(x10) skipped
00939463 // bne  x7, x9, +8 not taken
00452a23 // sw   x4, 20(x10)
00209663 // bne  x1, x2, +12 taken
00152c23 // sw   x1, 24(x10) skipped
00252e23 // sw   x2, 28(x10) skipped
00c005ef // jal  x11, +12
00152c23 // sw   x1, 24(x10) skipped
7ff00593 // addi x11, x0, 0x7ff skipped
00b52c23 // sw   x11, 24(x10)
f9c58613 // addi x12, x11, -100
00300693 // addi x13, x0, 3
40d60733 // sub  x14, x12, x13
00e52e23 // sw   x14, 28(x10)
0000006f // jal  x0, 0
// Expected stores
00001000 12345678
00001004 12345bfe
00001008 12345c7f
0000100c 00000001
00001010 00000000
00001014 00000585
00001018 00000164
0000101c 000000fd

// File: tb/core_tb.sv
/* Testbench for riscv_core with clock, reset, random delay bus models,
   program and expected stores from the test data file */
module core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam core_pkg::word_t BOOT_ADDR  = 32'h0000_0100;
  localparam int              DATA_WORDS = 256;

  logic            clk_i;
  logic            rst_n_i;
  logic            fetch_enable_i;
  core_pkg::word_t boot_addr_i;
  logic            instr_req_o;
  core_pkg::word_t instr_addr_o;
  logic            instr_gnt_i;
  logic            instr_rvalid_i;
  core_pkg::word_t instr_rdata_i;
  logic            data_req_o;
  logic            data_we_o;
  logic [3:0]      data_be_o;
  core_pkg::word_t data_addr_o;
  core_pkg::word_t data_wdata_o;
  logic            data_gnt_i;

  // Header, program words, then address/data pairs
  core_pkg::word_t tdata [0:DATA_WORDS-1];
  int              n_instr;
  int              n_stores;
  int              store_cnt;
  logic            loaded;
  int              seed;

  // Bus model state
  logic            instr_busy;
  core_pkg::word_t pend_addr;
  int              gnt_wait;
  int              rvalid_wait;
  int              data_wait;
  logic            first_fetch;

  riscv_core uut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .data_req_o     (data_req_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_addr_o    (data_addr_o),
    .data_wdata_o   (data_wdata_o),
    .data_gnt_i     (data_gnt_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic check_value(input string name, input core_pkg::word_t expected,
                             input core_pkg::word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %s expected %h got %h", name, expected, actual));
    end
  endtask

  // Random wait of 0 to span-1 cycles
  function automatic int pick_delay(input int span);
    return $unsigned($random(seed)) % span;
  endfunction

  // Outside the program reads as ADDI x0,x0,0
  function automatic core_pkg::word_t fetch_word(input core_pkg::word_t addr);
    core_pkg::word_t offset;
    int              idx;
    offset = addr - BOOT_ADDR;
    idx    = int'(offset >> 2);
    if ((addr >= BOOT_ADDR) && (idx < n_instr)) return tdata[2 + idx];
    return core_pkg::NOP_INSTR;
  endfunction

  ////////////////////
  // Bus models
  ////////////////////
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      data_gnt_i     <= 1'b0;
      store_cnt      <= 0;
      instr_busy      = 1'b0;
      pend_addr       = '0;
      gnt_wait        = 0;
      rvalid_wait     = 0;
      data_wait       = 0;
      first_fetch     = 1'b1;
    end else begin
      if ((instr_req_o || data_req_o) && !fetch_enable_i) begin
        abort_run("bus request seen before fetch enable");
      end
      // First fetch comes from the boot address
      if (instr_req_o && first_fetch) begin
        check_value("instr_addr_o", BOOT_ADDR, instr_addr_o);
        first_fetch = 1'b0;
      end
      // Instruction grant
      if (instr_req_o && instr_gnt_i) begin
        instr_gnt_i <= 1'b0;
        instr_busy   = 1'b1;
        pend_addr    = instr_addr_o;
        rvalid_wait  = pick_delay(4);
        gnt_wait     = pick_delay(4);
      end else if (instr_req_o) begin
        if (gnt_wait == 0) instr_gnt_i <= 1'b1;
        else gnt_wait--;
      end
      // Response, one cycle after grant at the earliest
      instr_rvalid_i <= 1'b0;
      if (instr_busy) begin
        if (rvalid_wait == 0) begin
          instr_rvalid_i <= 1'b1;
          instr_rdata_i  <= fetch_word(pend_addr);
          instr_busy      = 1'b0;
        end else begin
          rvalid_wait--;
        end
      end
      // Store completes on the grant edge
      if (data_req_o && data_gnt_i) begin
        data_gnt_i <= 1'b0;
        data_wait   = pick_delay(5);
        if (store_cnt >= n_stores) begin
          abort_run($sformatf("unexpected store of %h to address %h",
                              data_wdata_o, data_addr_o));
        end else begin
          check_value("data_addr_o", tdata[2 + n_instr + 2 * store_cnt], data_addr_o);
          check_value("data_wdata_o", tdata[3 + n_instr + 2 * store_cnt], data_wdata_o);
          check_value("data_we_o", 32'd1, {31'b0, data_we_o});
          check_value("data_be_o", 32'h0000_000f, {28'b0, data_be_o});
          store_cnt <= store_cnt + 1;
        end
      end else if (data_req_o) begin
        if (data_wait == 0) data_gnt_i <= 1'b1;
        else data_wait--;
      end
    end
  end

  // Bound checker failures
  always @(posedge clk_i) begin
    if (uut.core_chk_i.fail_count != 0) abort_run("bus protocol assertion failed");
  end

  ////////////////////
  // Sequence
  ////////////////////
  initial begin
    seed           = 32'h5cd3;
    loaded         = 1'b0;
    rst_n_i        = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    $readmemh("tb/core_testdata.hex", tdata);
    if ($isunknown(tdata[0]) || $isunknown(tdata[1])) begin
      abort_run("test data file is missing or has no header");
    end
    n_instr  = int'(tdata[0]);
    n_stores = int'(tdata[1]);
    if ((n_instr < 1) || (2 + n_instr + 2 * n_stores > DATA_WORDS)) begin
      abort_run("test data header gives sizes that do not fit");
    end
    loaded = 1'b1;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Core must stay off the buses until enabled
    repeat (6) @(posedge clk_i);
    fetch_enable_i <= 1'b1;
    while (store_cnt < n_stores) @(posedge clk_i);
    // Quiet period catches late wrong-path stores
    repeat (50) @(posedge clk_i);
    if ((store_cnt == n_stores) && (uut.core_chk_i.fail_count == 0)) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      abort_run("store count or checker state wrong at the end of the run");
    end
  end

  // Watchdog scaled by program and store count
  initial begin
    wait (loaded === 1'b1);
    repeat ((n_instr + n_stores) * 40 + 500) @(posedge clk_i);
    abort_run($sformatf("timeout with %0d of %0d expected stores seen",
                        store_cnt, n_stores));
  end

endmodule

// File: tb/core_chk.sv
/* Bus handshake assertions for riscv_core,
   bound into every core instance */
module core_chk (
  input logic            clk_i,
  input logic            rst_n_i,
  input logic            instr_req_o,
  input core_pkg::word_t instr_addr_o,
  input logic            instr_gnt_i,
  input logic            instr_rvalid_i,
  input logic            data_req_o,
  input logic            data_we_o,
  input logic [3:0]      data_be_o,
  input core_pkg::word_t data_addr_o,
  input core_pkg::word_t data_wdata_o,
  input logic            data_gnt_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Read by the testbench top
  int unsigned fail_count = 0;
  logic        outstanding_q;

  // Granted fetch still waiting for rvalid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 1'b0;
    end else if (instr_req_o && instr_gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (instr_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  ////////////////////
  // Handshakes
  ////////////////////
  instr_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else begin
      $error("instruction request dropped or changed before grant");
      fail_count++;
    end

  data_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_req_o && !data_gnt_i |=>
      data_req_o && $stable(data_addr_o) && $stable(data_wdata_o))
    else begin
      $error("data request dropped or changed before grant");
      fail_count++;
    end

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_rvalid_i |-> outstanding_q)
    else begin
      $error("instruction rvalid without an outstanding grant");
      fail_count++;
    end

  // Full word writes only
  data_full_word: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_req_o |-> (data_be_o == 4'b1111) && data_we_o)
    else begin
      $error("data request is not a full word write");
      fail_count++;
    end

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> !instr_req_o && !data_req_o)
    else begin
      $error("bus request while in reset");
      fail_count++;
    end

endmodule

bind riscv_core core_chk core_chk_i (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .instr_req_o    (instr_req_o),
  .instr_addr_o   (instr_addr_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_rvalid_i (instr_rvalid_i),
  .data_req_o     (data_req_o),
  .data_we_o      (data_we_o),
  .data_be_o      (data_be_o),
  .data_addr_o    (data_addr_o),
  .data_wdata_o   (data_wdata_o),
  .data_gnt_i     (data_gnt_i)
);

// File: hw/riscv_core.sv
/* Core top level with IF, ID and EX stages,
   the controller and the register file */
module riscv_core (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            fetch_enable_i,
  input  core_pkg::word_t boot_addr_i,
  // Instruction bus
  output logic            instr_req_o,
  output core_pkg::word_t instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  core_pkg::word_t instr_rdata_i,
  // Data bus, stores only
  output logic            data_req_o,
  output logic            data_we_o,
  output logic [3:0]      data_be_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  input  logic            data_gnt_i
);

  // Pipeline registers
  core_pkg::if_id_pipe_t if_id_pipe;
  core_pkg::id_ex_pipe_t id_ex_pipe;
  core_pkg::ex_wb_pipe_t ex_wb_pipe;
  core_pkg::ctrl_t       ctrl;

  // Register file read side
  core_pkg::reg_addr_t rs1;
  core_pkg::reg_addr_t rs2;
  core_pkg::word_t     rf_rdata_a;
  core_pkg::word_t     rf_rdata_b;

  // Redirects, bypass and stall sources
  logic            jump;
  core_pkg::word_t jump_target;
  logic            branch_taken;
  core_pkg::word_t branch_target;
  core_pkg::word_t ex_result;
  logic            store_wait;
  logic            fetch_start;

  ////////////////////
  // Stages
  ////////////////////
  if_stage if_stage_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_start_i  (fetch_start),
    .ctrl_i         (ctrl),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .if_id_pipe_o   (if_id_pipe)
  );

  id_stage id_stage_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .if_id_pipe_i  (if_id_pipe),
    .ctrl_i        (ctrl),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .ex_result_i   (ex_result),
    .ex_wb_pipe_i  (ex_wb_pipe),
    .jump_o        (jump),
    .jump_target_o (jump_target),
    .id_ex_pipe_o  (id_ex_pipe)
  );

  ex_stage ex_stage_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .id_ex_pipe_i    (id_ex_pipe),
    .ctrl_i          (ctrl),
    .data_req_o      (data_req_o),
    .data_we_o       (data_we_o),
    .data_be_o       (data_be_o),
    .data_addr_o     (data_addr_o),
    .data_wdata_o    (data_wdata_o),
    .data_gnt_i      (data_gnt_i),
    .store_wait_o    (store_wait),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .ex_result_o     (ex_result),
    .ex_wb_pipe_o    (ex_wb_pipe)
  );

  ////////////////////
  // Register file and control
  ////////////////////
  register_file register_file_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .rdata_a_o    (rf_rdata_a),
    .rdata_b_o    (rf_rdata_b),
    .ex_wb_pipe_i (ex_wb_pipe)
  );

  controller controller_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch_enable_i  (fetch_enable_i),
    .boot_addr_i     (boot_addr_i),
    .if_id_pipe_i    (if_id_pipe),
    .rs1_i           (rs1),
    .rs2_i           (rs2),
    .id_ex_pipe_i    (id_ex_pipe),
    .jump_i          (jump),
    .jump_target_i   (jump_target),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .store_wait_i    (store_wait),
    .ex_wb_pipe_i    (ex_wb_pipe),
    .fetch_start_o   (fetch_start),
    .ctrl_o          (ctrl)
  );

endmodule

// File: hw/controller.sv
/* Fetch start, bypass source selection, store stalls
   and redirect/flush control */
module controller (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  fetch_enable_i,
  input  core_pkg::word_t       boot_addr_i,
  input  core_pkg::if_id_pipe_t if_id_pipe_i,
  input  core_pkg::reg_addr_t   rs1_i,
  input  core_pkg::reg_addr_t   rs2_i,
  input  core_pkg::id_ex_pipe_t id_ex_pipe_i,
  input  logic                  jump_i,
  input  core_pkg::word_t       jump_target_i,
  input  logic                  branch_taken_i,
  input  core_pkg::word_t       branch_target_i,
  input  logic                  store_wait_i,
  input  core_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  output logic                  fetch_start_o,
  output core_pkg::ctrl_t       ctrl_o
);

  logic started_q;
  logic start_q;

  // One start pulse per reset, the cycle after enable is seen
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      started_q <= 1'b0;
      start_q   <= 1'b0;
    end else begin
      started_q <= started_q || fetch_enable_i;
      start_q   <= fetch_enable_i && !started_q;
    end
  end

  assign fetch_start_o = start_q;

  // EX result wins over WB, x0 never bypassed
  function automatic core_pkg::fwd_sel_e fwd_sel(input core_pkg::reg_addr_t rs);
    core_pkg::fwd_sel_e sel;
    sel = core_pkg::RF;
    if (if_id_pipe_i.valid && (rs != '0)) begin
      if (id_ex_pipe_i.valid && id_ex_pipe_i.rf_we && (id_ex_pipe_i.rf_waddr == rs)) begin
        sel = core_pkg::EX;
      end else if (ex_wb_pipe_i.valid && ex_wb_pipe_i.rf_we &&
                   (ex_wb_pipe_i.rf_waddr == rs)) begin
        sel = core_pkg::WB;
      end
    end
    return sel;
  endfunction

  ////////////////////
  // Control word
  ////////////////////
  always_comb begin
    ctrl_o         = '0;
    ctrl_o.fwd_a   = fwd_sel(rs1_i);
    ctrl_o.fwd_b   = fwd_sel(rs2_i);
    // Pending store freezes IF and ID
    ctrl_o.halt_if = store_wait_i;
    ctrl_o.halt_id = store_wait_i;
    if (branch_taken_i) begin
      // Branch in EX flushes both younger entries
      ctrl_o.pc_set    = 1'b1;
      ctrl_o.pc_target = branch_target_i;
      ctrl_o.kill_if   = 1'b1;
      ctrl_o.kill_id   = 1'b1;
    end else if (jump_i && !store_wait_i) begin
      ctrl_o.pc_set    = 1'b1;
      ctrl_o.pc_target = jump_target_i;
      ctrl_o.kill_if   = 1'b1;
    end else if (start_q) begin
      ctrl_o.pc_set    = 1'b1;
      ctrl_o.pc_target = boot_addr_i;
    end
  end

endmodule

// File: hw/ex_stage.sv
/* Execute with ALU, BEQ/BNE decision, data bus store
   request and the EX/WB register */
module ex_stage (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  core_pkg::id_ex_pipe_t id_ex_pipe_i,
  input  core_pkg::ctrl_t       ctrl_i,
  output logic                  data_req_o,
  output logic                  data_we_o,
  output logic [3:0]            data_be_o,
  output core_pkg::word_t       data_addr_o,
  output core_pkg::word_t       data_wdata_o,
  input  logic                  data_gnt_i,
  output logic                  store_wait_o,
  output logic                  branch_taken_o,
  output core_pkg::word_t       branch_target_o,
  output core_pkg::word_t       ex_result_o,
  output core_pkg::ex_wb_pipe_t ex_wb_pipe_o
);

  core_pkg::word_t       op_a;
  core_pkg::word_t       op_b;
  core_pkg::word_t       alu_res;
  logic                  store;
  core_pkg::ex_wb_pipe_t ex_wb_q;

  assign op_a = id_ex_pipe_i.operand_a;
  assign op_b = id_ex_pipe_i.operand_b;

  ////////////////////
  // ALU
  ////////////////////
  always_comb begin
    case (id_ex_pipe_i.alu_op)
      core_pkg::ADD: alu_res = op_a + op_b;
      core_pkg::SUB: alu_res = op_a - op_b;
      core_pkg::AND: alu_res = op_a & op_b;
      core_pkg::OR:  alu_res = op_a | op_b;
      core_pkg::XOR: alu_res = op_a ^ op_b;
      core_pkg::SLT: alu_res = {{(core_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default:       alu_res = op_b;
    endcase
  end

  // Also the EX bypass source for ID
  assign ex_result_o = alu_res;

  // Taken when equality disagrees with the BNE flag
  assign branch_taken_o  = id_ex_pipe_i.valid && id_ex_pipe_i.is_branch &&
                           ((op_a == op_b) ^ id_ex_pipe_i.branch_ne);
  assign branch_target_o = id_ex_pipe_i.branch_target;

  ////////////////////
  // Store issue
  ////////////////////
  // ID/EX stays halted until grant, keeping the request stable
  assign store        = id_ex_pipe_i.valid && id_ex_pipe_i.is_store;
  assign data_req_o   = store;
  assign data_we_o    = store;
  assign data_be_o    = 4'b1111;
  assign data_addr_o  = alu_res;
  assign data_wdata_o = id_ex_pipe_i.store_data;
  assign store_wait_o = store && !data_gnt_i;

  // EX/WB holds while the controller halts on a pending store
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_wb_q <= '0;
    end else if (!ctrl_i.halt_id) begin
      ex_wb_q.valid    <= id_ex_pipe_i.valid;
      ex_wb_q.rf_we    <= id_ex_pipe_i.valid && id_ex_pipe_i.rf_we;
      ex_wb_q.rf_waddr <= id_ex_pipe_i.rf_waddr;
      ex_wb_q.rf_wdata <= alu_res;
    end
  end

  assign ex_wb_pipe_o = ex_wb_q;

endmodule

// File: hw/id_stage.sv
/* Decode with immediates, operand bypass muxes,
   JAL resolution and the ID/EX register */
module id_stage (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  core_pkg::if_id_pipe_t if_id_pipe_i,
  input  core_pkg::ctrl_t       ctrl_i,
  output core_pkg::reg_addr_t   rs1_o,
  output core_pkg::reg_addr_t   rs2_o,
  input  core_pkg::word_t       rf_rdata_a_i,
  input  core_pkg::word_t       rf_rdata_b_i,
  input  core_pkg::word_t       ex_result_i,
  input  core_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  output logic                  jump_o,
  output core_pkg::word_t       jump_target_o,
  output core_pkg::id_ex_pipe_t id_ex_pipe_o
);

  core_pkg::word_t       instr;
  core_pkg::word_t       pc;
  core_pkg::word_t       imm_i;
  core_pkg::word_t       imm_s;
  core_pkg::word_t       imm_b;
  core_pkg::word_t       imm_u;
  core_pkg::word_t       imm_j;
  core_pkg::word_t       rs1_val;
  core_pkg::word_t       rs2_val;
  logic [2:0]            funct3;
  logic                  is_jal;
  core_pkg::id_ex_pipe_t id_ex_d;
  core_pkg::id_ex_pipe_t id_ex_q;

  assign instr  = if_id_pipe_i.instr;
  assign pc     = if_id_pipe_i.pc;
  assign funct3 = instr[14:12];
  assign rs1_o  = instr[19:15];
  assign rs2_o  = instr[24:20];

  // Sign extended immediates per format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // Bypass muxes, source chosen by the controller
  always_comb begin
    case (ctrl_i.fwd_a)
      core_pkg::EX: rs1_val = ex_result_i;
      core_pkg::WB: rs1_val = ex_wb_pipe_i.rf_wdata;
      default:      rs1_val = rf_rdata_a_i;
    endcase
    case (ctrl_i.fwd_b)
      core_pkg::EX: rs2_val = ex_result_i;
      core_pkg::WB: rs2_val = ex_wb_pipe_i.rf_wdata;
      default:      rs2_val = rf_rdata_b_i;
    endcase
  end

  ////////////////////
  // Decoder
  ////////////////////
  always_comb begin
    is_jal                = 1'b0;
    id_ex_d.valid         = if_id_pipe_i.valid;
    id_ex_d.pc            = pc;
    id_ex_d.operand_a     = rs1_val;
    id_ex_d.operand_b     = rs2_val;
    id_ex_d.store_data    = rs2_val;
    id_ex_d.branch_target = pc + imm_b;
    id_ex_d.alu_op        = core_pkg::ADD;
    id_ex_d.rf_we         = 1'b0;
    id_ex_d.rf_waddr      = instr[11:7];
    id_ex_d.rs1           = rs1_o;
    id_ex_d.rs2           = rs2_o;
    id_ex_d.is_branch     = 1'b0;
    id_ex_d.branch_ne     = funct3[0];
    id_ex_d.is_store      = 1'b0;
    case (instr[6:0])
      core_pkg::OPC_LUI: begin
        id_ex_d.alu_op    = core_pkg::PASS_B;
        id_ex_d.operand_b = imm_u;
        id_ex_d.rf_we     = 1'b1;
      end
      core_pkg::OPC_OP_IMM: begin
        id_ex_d.operand_b = imm_i;
        id_ex_d.rf_we     = 1'b1;
        case (funct3)
          3'b000:  id_ex_d.alu_op = core_pkg::ADD;
          3'b100:  id_ex_d.alu_op = core_pkg::XOR;
          3'b110:  id_ex_d.alu_op = core_pkg::OR;
          3'b111:  id_ex_d.alu_op = core_pkg::AND;
          default: id_ex_d.rf_we  = 1'b0;
        endcase
      end
      core_pkg::OPC_OP: begin
        id_ex_d.rf_we = 1'b1;
        // funct7 and funct3 together, anything else is a no-op
        case ({instr[31:25], funct3})
          10'b0000000_000: id_ex_d.alu_op = core_pkg::ADD;
          10'b0100000_000: id_ex_d.alu_op = core_pkg::SUB;
          10'b0000000_111: id_ex_d.alu_op = core_pkg::AND;
          10'b0000000_110: id_ex_d.alu_op = core_pkg::OR;
          10'b0000000_100: id_ex_d.alu_op = core_pkg::XOR;
          10'b0000000_010: id_ex_d.alu_op = core_pkg::SLT;
          default:         id_ex_d.rf_we  = 1'b0;
        endcase
      end
      // BEQ and BNE only
      core_pkg::OPC_BRANCH: id_ex_d.is_branch = (funct3[2:1] == 2'b00);
      core_pkg::OPC_JAL: begin
        is_jal            = 1'b1;
        id_ex_d.alu_op    = core_pkg::PASS_B;
        id_ex_d.operand_b = pc + 32'd4;
        id_ex_d.rf_we     = 1'b1;
      end
      core_pkg::OPC_STORE: begin
        // SW only, address is rs1 + imm through the ALU
        id_ex_d.is_store  = (funct3 == 3'b010);
        id_ex_d.operand_b = imm_s;
      end
      default: ;
    endcase
  end

  assign jump_o        = if_id_pipe_i.valid && is_jal;
  assign jump_target_o = pc + imm_j;

  // ID/EX, kill before halt
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_q <= '0;
    end else if (ctrl_i.kill_id) begin
      id_ex_q <= '0;
    end else if (!ctrl_i.halt_id) begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_pipe_o = id_ex_q;

endmodule

// File: hw/if_stage.sv
/* Instruction fetch with bus master FSM, program counter,
   stale response discard, skid entry and IF/ID register */
module if_stage (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  fetch_start_i,
  input  core_pkg::ctrl_t       ctrl_i,
  output logic                  instr_req_o,
  output core_pkg::word_t       instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  core_pkg::word_t       instr_rdata_i,
  output core_pkg::if_id_pipe_t if_id_pipe_o
);

  core_pkg::fetch_state_e state_q;
  core_pkg::fetch_state_e state_d;
  core_pkg::word_t        next_pc_q;
  core_pkg::word_t        pc_d;
  core_pkg::word_t        addr_q;
  core_pkg::if_id_pipe_t  if_id_q;
  core_pkg::if_id_pipe_t  skid_q;
  core_pkg::if_id_pipe_t  fetched;
  core_pkg::if_id_pipe_t  nop_entry;
  logic                   running_q;
  logic                   discard_q;
  logic                   skid_valid_q;
  logic                   resp;
  logic                   accept;
  logic                   if_ld;
  logic                   issue;

  assign fetched   = '{valid: 1'b1, pc: addr_q, instr: instr_rdata_i};
  assign nop_entry = '{valid: 1'b0, pc: '0, instr: core_pkg::NOP_INSTR};

  // Response to the one outstanding request
  assign resp   = (state_q == core_pkg::WAIT_RVALID) && instr_rvalid_i;
  // Stale after a redirect, or redirected right now
  assign accept = resp && !discard_q && !ctrl_i.pc_set;
  // IF/ID takes a new entry unless full and halted
  assign if_ld  = !ctrl_i.halt_if || !if_id_q.valid;

  // New request from IDLE or straight after rvalid
  // Blocked while the skid entry is (or is about to be) occupied
  assign issue = (running_q || fetch_start_i) && !skid_valid_q && !(accept && !if_ld) &&
                 ((state_q == core_pkg::IDLE) || resp);

  // Redirect first, then sequential
  assign pc_d = ctrl_i.pc_set ? ctrl_i.pc_target :
                accept        ? addr_q + 32'd4   : next_pc_q;

  ////////////////////
  // Fetch FSM
  ////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      core_pkg::IDLE: begin
        if (issue) state_d = core_pkg::WAIT_GNT;
      end
      core_pkg::WAIT_GNT: begin
        if (instr_gnt_i) state_d = core_pkg::WAIT_RVALID;
      end
      core_pkg::WAIT_RVALID: begin
        if (instr_rvalid_i) state_d = issue ? core_pkg::WAIT_GNT : core_pkg::IDLE;
      end
      default: state_d = core_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= core_pkg::IDLE;
      running_q <= 1'b0;
      discard_q <= 1'b0;
      next_pc_q <= '0;
      addr_q    <= '0;
    end else begin
      state_q   <= state_d;
      running_q <= running_q || fetch_start_i;
      next_pc_q <= pc_d;
      // Address frozen until the next issue
      if (issue) addr_q <= pc_d;
      // Remember a redirect made while a response is pending
      if (resp) begin
        discard_q <= 1'b0;
      end else if (ctrl_i.pc_set && (state_q != core_pkg::IDLE)) begin
        discard_q <= 1'b1;
      end
    end
  end

  ////////////////////
  // IF/ID and skid
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_id_q      <= nop_entry;
      skid_valid_q <= 1'b0;
    end else if (ctrl_i.kill_if) begin
      if_id_q      <= nop_entry;
      skid_valid_q <= 1'b0;
    end else if (if_ld) begin
      // Skid entry is older than any new word
      if_id_q      <= skid_valid_q ? skid_q : (accept ? fetched : nop_entry);
      skid_valid_q <= 1'b0;
    end else if (accept) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && !if_ld) skid_q <= fetched;
  end

  assign instr_req_o  = (state_q == core_pkg::WAIT_GNT);
  assign instr_addr_o = addr_q;
  assign if_id_pipe_o = if_id_q;

endmodule

// File: hw/register_file.sv
/* Registers x1 to x31, x0 hardwired to zero,
   two read ports with write-through */
module register_file (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  core_pkg::reg_addr_t   rs1_i,
  input  core_pkg::reg_addr_t   rs2_i,
  output core_pkg::word_t       rdata_a_o,
  output core_pkg::word_t       rdata_b_o,
  input  core_pkg::ex_wb_pipe_t ex_wb_pipe_i
);

  core_pkg::word_t regs_q [1:core_pkg::NUM_REGS-1];
  logic            we;

  // Writes to x0 dropped
  assign we = ex_wb_pipe_i.valid && ex_wb_pipe_i.rf_we && (ex_wb_pipe_i.rf_waddr != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < core_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we) begin
      regs_q[ex_wb_pipe_i.rf_waddr] <= ex_wb_pipe_i.rf_wdata;
    end
  end

  // Same-cycle write seen by the reader
  function automatic core_pkg::word_t read_port(input core_pkg::reg_addr_t addr);
    core_pkg::word_t val;
    if (addr == '0) val = '0;
    else if (we && (addr == ex_wb_pipe_i.rf_waddr)) val = ex_wb_pipe_i.rf_wdata;
    else val = regs_q[addr];
    return val;
  endfunction

  assign rdata_a_o = read_port(rs1_i);
  assign rdata_b_o = read_port(rs2_i);

endmodule

// File: hw/core_pkg.sv
/* Widths, RV32I opcodes, enums and pipeline structs
   for the three-stage integer core */
package core_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0]             word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

  ////////////////////
  // Encodings
  ////////////////////
  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // ADDI x0,x0,0 bubble word
  localparam word_t NOP_INSTR = 32'h0000_0013;

  // PASS_B forwards operand b, for LUI and the JAL link value
  typedef enum logic [2:0] {
    ADD, SUB, AND, OR, XOR, SLT, PASS_B
  } alu_op_e;

  // Operand source picked by the bypass logic
  typedef enum logic [1:0] {
    RF, EX, WB
  } fwd_sel_e;

  typedef enum logic [1:0] {
    IDLE, WAIT_GNT, WAIT_RVALID
  } fetch_state_e;

  ////////////////////
  // Pipeline structs
  ////////////////////
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } if_id_pipe_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     operand_a;
    word_t     operand_b;
    word_t     store_data;
    word_t     branch_target;
    alu_op_e   alu_op;
    logic      rf_we;
    reg_addr_t rf_waddr;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      is_branch;
    logic      branch_ne;    // BNE when set, else BEQ
    logic      is_store;
  } id_ex_pipe_t;

  typedef struct packed {
    logic      valid;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
  } ex_wb_pipe_t;

  // Controller outputs to all stages
  typedef struct packed {
    logic     halt_if;
    logic     halt_id;
    logic     kill_if;
    logic     kill_id;
    logic     pc_set;
    word_t    pc_target;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
  } ctrl_t;

endpackage
